// File: flist.f
+incdir+src
src/cache_geom_pkg.sv
src/mhu_msg_pkg.sv
src/replacement_picker.sv
src/secondary_dequeue.sv
src/miss_fsm.sv
src/miss_handling_unit.sv
test/mhu_tb.sv

// File: test/mhu_tb.sv
// directed tests for the miss handling unit
// miss FIFO queue, set state memory and DMA responder models
// LFSR back-pressure on data packets and DMA commands

`default_nettype none

module mhu_tb;

  import cache_geom_pkg::*;
  import mhu_msg_pkg::*;

  `include "mhu_settings.svh"

  localparam int timeout_cycles_c = 2000;

  logic clk_i;
  logic reset_i;
  logic miss_fifo_v_i;
  miss_entry_s miss_fifo_entry_i;
  logic miss_fifo_yumi_o;
  set_state_s set_state_i;
  logic tag_mem_pkt_v_o;
  tag_mem_pkt_s tag_mem_pkt_o;
  logic stat_mem_pkt_v_o;
  stat_mem_pkt_s stat_mem_pkt_o;
  logic data_mem_pkt_v_o;
  data_mem_pkt_s data_mem_pkt_o;
  logic data_mem_pkt_yumi_i;
  logic dma_cmd_v_o;
  dma_cmd_s dma_cmd_o;
  logic dma_cmd_ready_i;
  logic dma_done_i;
  logic dma_ack_o;
  logic idle_o;

  miss_entry_s fifo_q[$];
  dma_cmd_s cmd_log[$];
  tag_mem_pkt_s tag_wr_log[$];
  data_mem_pkt_s pkt_log[$];
  logic pkt_yumi_log[$];
  set_state_s sets [`MHU_SETS];
  logic dma_busy;
  int done_wait;
  int cycle_count;
  int next_id;
  logic [7:0] lfsr_r;

  miss_handling_unit dut0 (.*);

  // x^8 + x^6 + x^5 + x^4
  function automatic logic random_bit();
    logic fb;
    fb = lfsr_r[7] ^ lfsr_r[5] ^ lfsr_r[4] ^ lfsr_r[3];
    lfsr_r = {lfsr_r[6:0], fb};
    return fb;
  endfunction

  // {tag, index, word offset, byte select}
  function automatic addr_t make_addr(input tag_t tag, input index_t index, input word_off_t word,
                                      input byte_sel_t bsel);
    return {tag, index, word, bsel};
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // sample the models at each rising edge and drive the next inputs
  task automatic respond_at_edge();
    if (miss_fifo_yumi_o) begin
      assert (miss_fifo_v_i && fifo_q.size() != 0) else begin
        fail_now("miss FIFO yumi while no entry was valid");
      end
      fifo_q.delete(0);
    end
    if (data_mem_pkt_v_o && data_mem_pkt_yumi_i) begin
      pkt_log.push_back(data_mem_pkt_o);
      pkt_yumi_log.push_back(miss_fifo_yumi_o);
    end
    if (dma_ack_o) begin
      assert (dma_done_i) else fail_now("DMA ack given without done");
      dma_busy = 1'b0;
      dma_done_i <= 1'b0;
    end
    if (dma_cmd_v_o && dma_cmd_ready_i) begin
      assert (!dma_busy) else fail_now("second DMA command while one was in flight");
      cmd_log.push_back(dma_cmd_o);
      dma_busy = 1'b1;
      done_wait = 2 + 2 * random_bit() + random_bit();
    end else if (dma_busy && !dma_done_i) begin
      if (done_wait == 0) begin
        dma_done_i <= 1'b1;
      end else begin
        done_wait--;
      end
    end
    if (tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == e_tag_read) begin
      assert (stat_mem_pkt_v_o && stat_mem_pkt_o.opcode == e_stat_read
              && stat_mem_pkt_o.index == tag_mem_pkt_o.index) else begin
        fail_now("tag read came without a matching stat read packet");
      end
      set_state_i <= sets[tag_mem_pkt_o.index];
    end else if (tag_mem_pkt_v_o) begin
      assert (stat_mem_pkt_v_o && stat_mem_pkt_o.opcode == e_stat_clear_dirty
              && stat_mem_pkt_o.way == tag_mem_pkt_o.way
              && stat_mem_pkt_o.index == tag_mem_pkt_o.index) else begin
        fail_now("tag write came without a matching clear_dirty packet");
      end
      tag_wr_log.push_back(tag_mem_pkt_o);
      sets[tag_mem_pkt_o.index].tag[tag_mem_pkt_o.way] = tag_mem_pkt_o.tag;
      sets[tag_mem_pkt_o.index].valid[tag_mem_pkt_o.way] = 1'b1;
      sets[stat_mem_pkt_o.index].dirty[stat_mem_pkt_o.way] = 1'b0;
    end
    data_mem_pkt_yumi_i <= random_bit() | random_bit();
    dma_cmd_ready_i <= random_bit();
    miss_fifo_v_i <= (fifo_q.size() != 0);
    if (fifo_q.size() != 0) begin
      miss_fifo_entry_i <= fifo_q[0];
    end
  endtask

  task automatic load_set(input index_t index, input logic [3:0] valid, input logic [3:0] lock,
                          input logic [3:0] dirty, input way_t lru);
    @(negedge clk_i);
    sets[index].valid = valid;
    sets[index].lock = lock;
    sets[index].dirty = dirty;
    sets[index].lru_way = lru;
  endtask

  task automatic push_entry(input tag_t tag, input index_t index, input word_off_t word,
                            input logic wnr, input logic block_load, input word_t data);
    miss_entry_s e;
    e.id = id_t'(next_id);
    // byte select, size and sign extension taken from the low data bits
    e.addr = make_addr(tag, index, word, data[4:3]);
    e.write_not_read = wnr;
    e.block_load = block_load;
    e.size_op = data[1:0];
    e.sigext_op = data[2];
    e.data = data;
    next_id++;
    @(negedge clk_i);
    fifo_q.push_back(e);
  endtask

  task automatic check_cmd(input way_t way, input index_t index, input tag_t tag,
                           input logic evict, input tag_t evict_tag);
    dma_cmd_s cmd;
    while (cmd_log.size() == 0) @(negedge clk_i);
    cmd = cmd_log.pop_front();
    check_value("dma_cmd_o.way", cmd.way, way);
    check_value("dma_cmd_o.index", cmd.index, index);
    check_value("dma_cmd_o.refill", cmd.refill, 1'b1);
    check_value("dma_cmd_o.refill_tag", cmd.refill_tag, tag);
    check_value("dma_cmd_o.evict", cmd.evict, evict);
    if (evict) begin
      check_value("dma_cmd_o.evict_tag", cmd.evict_tag, evict_tag);
    end
  endtask

  task automatic check_tag_write(input way_t way, input index_t index, input tag_t tag);
    tag_mem_pkt_s pkt;
    while (tag_wr_log.size() == 0) @(negedge clk_i);
    pkt = tag_wr_log.pop_front();
    check_value("tag_mem_pkt_o.way", pkt.way, way);
    check_value("tag_mem_pkt_o.index", pkt.index, index);
    check_value("tag_mem_pkt_o.tag", pkt.tag, tag);
  endtask

  task automatic take_pkt(output data_mem_pkt_s pkt, output logic yumi);
    while (pkt_log.size() == 0) @(negedge clk_i);
    pkt = pkt_log.pop_front();
    yumi = pkt_yumi_log.pop_front();
  endtask

  task automatic check_pkt(input way_t way, input index_t index, input word_off_t word,
                           input logic wnr, input word_t data);
    data_mem_pkt_s pkt;
    logic yumi;
    take_pkt(pkt, yumi);
    check_value("data_mem_pkt_o.way", pkt.way, way);
    check_value("data_mem_pkt_o.index", pkt.index, index);
    check_value("data_mem_pkt_o.word", pkt.word, word);
    check_value("data_mem_pkt_o.byte_sel", pkt.byte_sel, data[4:3]);
    check_value("data_mem_pkt_o.size_op", pkt.size_op, data[1:0]);
    check_value("data_mem_pkt_o.sigext_op", pkt.sigext_op, data[2]);
    check_value("data_mem_pkt_o.write_not_read", pkt.write_not_read, wnr);
    check_value("data_mem_pkt_o.data", pkt.data, data);
    check_value("miss_fifo_yumi_o", yumi, 1'b1);
  endtask

  // unit settles in idle once the FIFO is empty and the DMA acked
  task automatic wait_drained();
    while (fifo_q.size() != 0 || dma_busy) @(negedge clk_i);
    repeat (4) begin
      if (!idle_o) @(negedge clk_i);
    end
    assert (idle_o) else fail_now("idle_o stayed low with an empty FIFO and no DMA pending");
    assert (cmd_log.size() == 0 && pkt_log.size() == 0 && tag_wr_log.size() == 0) else begin
      fail_now("unexpected extra DMA command, tag write or data packet");
    end
  endtask

  task automatic serve_single_miss(input tag_t tag, input index_t index, input word_off_t word,
                                   input way_t way, input logic evict, input tag_t evict_tag);
    word_t data;
    data = {tag[10:0], index, word, 12'h5be};
    push_entry(tag, index, word, 1'b0, 1'b0, data);
    check_cmd(way, index, tag, evict, evict_tag);
    check_tag_write(way, index, tag);
    check_pkt(way, index, word, 1'b0, data);
    wait_drained();
  endtask

  task automatic test_invalid_way();
    // ways 0 and 3 taken and way 1 invalid but locked
    load_set(6'd5, 4'b1001, 4'b0010, 4'b1001, 2'd0);
    serve_single_miss(21'h1a2b3, 6'd5, 3'd3, 2'd2, 1'b0, '0);
  endtask

  task automatic test_lru_victim();
    load_set(6'd9, 4'b1111, 4'b0000, 4'b0100, 2'd2);
    serve_single_miss(21'h0c0de, 6'd9, 3'd6, 2'd2, 1'b1, sets[9].tag[2]);
  endtask

  task automatic test_locked_lru();
    load_set(6'd12, 4'b1111, 4'b0011, 4'b0100, 2'd1);
    serve_single_miss(21'h15555, 6'd12, 3'd0, 2'd2, 1'b1, sets[12].tag[2]);
  endtask

  task automatic test_secondary_misses();
    load_set(6'd20, 4'b0000, 4'b0000, 4'b0000, 2'd3);
    push_entry(21'h0beef, 6'd20, 3'd1, 1'b1, 1'b0, 32'hcafe_0001);
    push_entry(21'h0beef, 6'd20, 3'd3, 1'b0, 1'b0, 32'hcafe_0003);
    push_entry(21'h0beef, 6'd20, 3'd7, 1'b1, 1'b0, 32'hcafe_0017);
    check_cmd(2'd0, 6'd20, 21'h0beef, 1'b0, '0);
    check_tag_write(2'd0, 6'd20, 21'h0beef);
    check_pkt(2'd0, 6'd20, 3'd1, 1'b1, 32'hcafe_0001);
    check_pkt(2'd0, 6'd20, 3'd3, 1'b0, 32'hcafe_0003);
    check_pkt(2'd0, 6'd20, 3'd7, 1'b1, 32'hcafe_0017);
    wait_drained();
  endtask

  task automatic test_block_load();
    data_mem_pkt_s pkt;
    logic yumi;
    load_set(6'd33, 4'b0000, 4'b0001, 4'b0000, 2'd0);
    // entry carries byte size, sign extension and a byte select that the unit overrides
    push_entry(21'h00777, 6'd33, 3'd5, 1'b0, 1'b1, 32'h0000_001f);
    check_cmd(2'd1, 6'd33, 21'h00777, 1'b0, '0);
    check_tag_write(2'd1, 6'd33, 21'h00777);
    for (int i = 0; i < `MHU_BLOCK_WORDS; i++) begin
      take_pkt(pkt, yumi);
      check_value("data_mem_pkt_o.way", pkt.way, 2'd1);
      check_value("data_mem_pkt_o.index", pkt.index, 6'd33);
      check_value("data_mem_pkt_o.word", pkt.word, i);
      check_value("data_mem_pkt_o.byte_sel", pkt.byte_sel, 2'd0);
      check_value("data_mem_pkt_o.size_op", pkt.size_op, 2'd2);
      check_value("data_mem_pkt_o.sigext_op", pkt.sigext_op, 1'b0);
      check_value("miss_fifo_yumi_o", yumi, i == `MHU_BLOCK_WORDS - 1);
    end
    wait_drained();
  endtask

  task automatic test_next_miss();
    load_set(6'd40, 4'b0001, 4'b0000, 4'b0000, 2'd0);
    load_set(6'd41, 4'b0000, 4'b0000, 4'b0000, 2'd0);
    push_entry(21'h12345, 6'd40, 3'd2, 1'b0, 1'b0, 32'h4002_0000);
    push_entry(21'h12345, 6'd40, 3'd5, 1'b1, 1'b0, 32'h4005_0000);
    push_entry(21'h0abcd, 6'd41, 3'd0, 1'b0, 1'b0, 32'h4100_0000);
    check_cmd(2'd1, 6'd40, 21'h12345, 1'b0, '0);
    check_tag_write(2'd1, 6'd40, 21'h12345);
    check_pkt(2'd1, 6'd40, 3'd2, 1'b0, 32'h4002_0000);
    check_pkt(2'd1, 6'd40, 3'd5, 1'b1, 32'h4005_0000);
    check_cmd(2'd0, 6'd41, 21'h0abcd, 1'b0, '0);
    check_tag_write(2'd0, 6'd41, 21'h0abcd);
    check_pkt(2'd0, 6'd41, 3'd0, 1'b0, 32'h4100_0000);
    wait_drained();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // memory, DMA and FIFO models plus the cycle limit
  initial begin
    lfsr_r = 8'd82;
    cycle_count = 0;
    next_id = 0;
    dma_busy = 1'b0;
    done_wait = 0;
    miss_fifo_v_i = 1'b0;
    miss_fifo_entry_i = '0;
    set_state_i = '0;
    data_mem_pkt_yumi_i = 1'b0;
    dma_cmd_ready_i = 1'b0;
    dma_done_i = 1'b0;
    for (int i = 0; i < `MHU_SETS; i++) begin
      sets[i] = '0;
      sets[i].lru_way = way_t'(i);
      for (int w = 0; w < `MHU_WAYS; w++) begin
        sets[i].tag[w] = tag_t'((i * 4 + w) * 32'h9e37 + 32'h15a5a);
      end
    end
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count > timeout_cycles_c) begin
        fail_now("timeout: the tests did not finish within the cycle limit");
      end
      if (!reset_i) begin
        respond_at_edge();
      end
    end
  end

  initial begin
    reset_i = 1'b1;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("idle_o", idle_o, 1'b1);
    check_value("miss_fifo_yumi_o", miss_fifo_yumi_o, 1'b0);
    check_value("dma_cmd_v_o", dma_cmd_v_o, 1'b0);
    check_value("dma_ack_o", dma_ack_o, 1'b0);
    check_value("data_mem_pkt_v_o", data_mem_pkt_v_o, 1'b0);
    check_value("tag_mem_pkt_v_o", tag_mem_pkt_v_o, 1'b0);
    check_value("stat_mem_pkt_v_o", stat_mem_pkt_v_o, 1'b0);
    test_invalid_way();
    test_lru_victim();
    test_locked_lru();
    test_secondary_misses();
    test_block_load();
    test_next_miss();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/miss_handling_unit.sv
// miss_handling_unit: load/store miss path of the non-blocking cache
// victim picker, miss FSM and secondary-miss dequeue

`default_nettype none

module miss_handling_unit (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // miss FIFO
  input  logic                       miss_fifo_v_i,
  input  mhu_msg_pkg::miss_entry_s   miss_fifo_entry_i,
  output logic                       miss_fifo_yumi_o,

  // tag and stat memories
  input  mhu_msg_pkg::set_state_s    set_state_i,
  output logic                       tag_mem_pkt_v_o,
  output mhu_msg_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                       stat_mem_pkt_v_o,
  output mhu_msg_pkg::stat_mem_pkt_s stat_mem_pkt_o,

  // data memory
  output logic                       data_mem_pkt_v_o,
  output mhu_msg_pkg::data_mem_pkt_s data_mem_pkt_o,
  input  logic                       data_mem_pkt_yumi_i,

  // DMA
  output logic                       dma_cmd_v_o,
  output mhu_msg_pkg::dma_cmd_s      dma_cmd_o,
  input  logic                       dma_cmd_ready_i,
  input  logic                       dma_done_i,
  output logic                       dma_ack_o,

  output logic                       idle_o
);

  import mhu_msg_pkg::*;

  victim_s victim;
  dma_cmd_s curr_cmd;
  logic dequeue_active;
  logic block_done;

  replacement_picker picker0 (
    .set_state_i(set_state_i),
    .victim_o   (victim)
  );

  miss_fsm fsm0 (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss_fifo_v_i    (miss_fifo_v_i),
    .miss_fifo_entry_i(miss_fifo_entry_i),
    .victim_i         (victim),
    .dma_cmd_ready_i  (dma_cmd_ready_i),
    .dma_done_i       (dma_done_i),
    .block_done_i     (block_done),
    .tag_mem_pkt_v_o  (tag_mem_pkt_v_o),
    .tag_mem_pkt_o    (tag_mem_pkt_o),
    .stat_mem_pkt_v_o (stat_mem_pkt_v_o),
    .stat_mem_pkt_o   (stat_mem_pkt_o),
    .dma_cmd_v_o      (dma_cmd_v_o),
    .dma_cmd_o        (dma_cmd_o),
    .dma_ack_o        (dma_ack_o),
    .curr_cmd_o       (curr_cmd),
    .dequeue_active_o (dequeue_active),
    .idle_o           (idle_o)
  );

  secondary_dequeue dequeue0 (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .active_i           (dequeue_active),
    .curr_cmd_i         (curr_cmd),
    .miss_fifo_v_i      (miss_fifo_v_i),
    .miss_fifo_entry_i  (miss_fifo_entry_i),
    .data_mem_pkt_yumi_i(data_mem_pkt_yumi_i),
    .data_mem_pkt_v_o   (data_mem_pkt_v_o),
    .data_mem_pkt_o     (data_mem_pkt_o),
    .miss_fifo_yumi_o   (miss_fifo_yumi_o),
    .block_done_o       (block_done)
  );

endmodule

`default_nettype wire

// File: src/miss_fsm.sv
// miss_fsm: primary miss sequencing
// set read, DMA command issue, fill completion, dequeue phase
// current miss register and tag/stat memory packets

`default_nettype none

module miss_fsm (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       miss_fifo_v_i,
  input  mhu_msg_pkg::miss_entry_s   miss_fifo_entry_i,
  input  mhu_msg_pkg::victim_s       victim_i,
  input  logic                       dma_cmd_ready_i,
  input  logic                       dma_done_i,
  input  logic                       block_done_i,
  output logic                       tag_mem_pkt_v_o,
  output mhu_msg_pkg::tag_mem_pkt_s  tag_mem_pkt_o,
  output logic                       stat_mem_pkt_v_o,
  output mhu_msg_pkg::stat_mem_pkt_s stat_mem_pkt_o,
  output logic                       dma_cmd_v_o,
  output mhu_msg_pkg::dma_cmd_s      dma_cmd_o,
  output logic                       dma_ack_o,
  output mhu_msg_pkg::dma_cmd_s      curr_cmd_o,
  output logic                       dequeue_active_o,
  output logic                       idle_o
);

  import cache_geom_pkg::*;
  import mhu_msg_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SEND_DMA,
    WAIT_DMA,
    DEQUEUE
  } state_e;

  state_e state_r;
  state_e state_n;
  index_t entry_index;
  dma_cmd_s curr_cmd_r;

  assign entry_index = addr_index(miss_fifo_entry_i.addr);

  // refill command for the entry at the FIFO head
  assign dma_cmd_o.way = victim_i.way;
  assign dma_cmd_o.index = entry_index;
  assign dma_cmd_o.refill = 1'b1;
  assign dma_cmd_o.refill_tag = addr_tag(miss_fifo_entry_i.addr);
  assign dma_cmd_o.evict = victim_i.evict;
  assign dma_cmd_o.evict_tag = victim_i.evict_tag;

  assign curr_cmd_o = curr_cmd_r;

  always_comb begin
    state_n = state_r;
    idle_o = 1'b0;
    dma_cmd_v_o = 1'b0;
    dma_ack_o = 1'b0;
    dequeue_active_o = 1'b0;

    tag_mem_pkt_v_o = 1'b0;
    tag_mem_pkt_o.opcode = e_tag_read;
    tag_mem_pkt_o.way = curr_cmd_r.way;
    tag_mem_pkt_o.index = entry_index;
    tag_mem_pkt_o.tag = curr_cmd_r.refill_tag;

    stat_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o.opcode = e_stat_read;
    stat_mem_pkt_o.way = curr_cmd_r.way;
    stat_mem_pkt_o.index = entry_index;

    case (state_r)
      IDLE: begin
        idle_o = ~miss_fifo_v_i;
        tag_mem_pkt_v_o = miss_fifo_v_i;
        stat_mem_pkt_v_o = miss_fifo_v_i;
        if (miss_fifo_v_i) begin
          state_n = SEND_DMA;
        end
      end

      // set state is valid from this cycle on
      SEND_DMA: begin
        dma_cmd_v_o = 1'b1;
        if (dma_cmd_ready_i) begin
          state_n = WAIT_DMA;
        end
      end

      WAIT_DMA: begin
        dma_ack_o = dma_done_i;
        tag_mem_pkt_v_o = dma_done_i;
        tag_mem_pkt_o.opcode = e_tag_set_tag;
        tag_mem_pkt_o.index = curr_cmd_r.index;
        stat_mem_pkt_v_o = dma_done_i;
        stat_mem_pkt_o.opcode = e_stat_clear_dirty;
        stat_mem_pkt_o.index = curr_cmd_r.index;
        if (dma_done_i) begin
          state_n = DEQUEUE;
        end
      end

      DEQUEUE: begin
        dequeue_active_o = 1'b1;
        if (block_done_i) begin
          state_n = IDLE;
        end
      end

      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // current miss captured on command transfer
  always_ff @(posedge clk_i) begin
    if ((state_r == SEND_DMA) && dma_cmd_ready_i) begin
      curr_cmd_r <= dma_cmd_o;
    end
  end

endmodule

`default_nettype wire

// File: src/secondary_dequeue.sv
// secondary_dequeue: drains miss FIFO entries of the filled block
// secondary-miss match against the current DMA command
// block-load word counter and data memory packet build

`default_nettype none

module secondary_dequeue (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       active_i,
  input  mhu_msg_pkg::dma_cmd_s      curr_cmd_i,
  input  logic                       miss_fifo_v_i,
  input  mhu_msg_pkg::miss_entry_s   miss_fifo_entry_i,
  input  logic                       data_mem_pkt_yumi_i,
  output logic                       data_mem_pkt_v_o,
  output mhu_msg_pkg::data_mem_pkt_s data_mem_pkt_o,
  output logic                       miss_fifo_yumi_o,
  output logic                       block_done_o
);

  import cache_geom_pkg::*;
  import mhu_msg_pkg::*;

  tag_t entry_tag;
  index_t entry_index;
  logic is_secondary;
  logic block_load;
  logic last_word;
  logic word_taken;
  word_off_t word_cnt_r;

  assign entry_tag = addr_tag(miss_fifo_entry_i.addr);
  assign entry_index = addr_index(miss_fifo_entry_i.addr);
  assign block_load = miss_fifo_entry_i.block_load;

  // same block as the one just refilled
  assign is_secondary = (entry_tag == curr_cmd_i.refill_tag)
                      & (entry_index == curr_cmd_i.index);

  assign block_done_o = ~miss_fifo_v_i | ~is_secondary;

  assign data_mem_pkt_v_o = active_i & miss_fifo_v_i & is_secondary;
  assign word_taken = data_mem_pkt_v_o & data_mem_pkt_yumi_i;
  assign last_word = (word_cnt_r == word_off_t'(block_words_c - 1));

  // block load leaves the FIFO only after its last word
  assign miss_fifo_yumi_o = word_taken & (~block_load | last_word);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      word_cnt_r <= '0;
    end else if (miss_fifo_yumi_o) begin
      word_cnt_r <= '0;
    end else if (word_taken & block_load) begin
      word_cnt_r <= word_cnt_r + 1'b1;
    end
  end

  always_comb begin
    data_mem_pkt_o.write_not_read = miss_fifo_entry_i.write_not_read;
    data_mem_pkt_o.way = curr_cmd_i.way;
    data_mem_pkt_o.index = curr_cmd_i.index;
    data_mem_pkt_o.data = miss_fifo_entry_i.data;
    if (block_load) begin
      // whole words, no sign extension
      data_mem_pkt_o.sigext_op = 1'b0;
      data_mem_pkt_o.size_op = size_word_c;
      data_mem_pkt_o.byte_sel = '0;
      data_mem_pkt_o.word = word_cnt_r;
    end else begin
      data_mem_pkt_o.sigext_op = miss_fifo_entry_i.sigext_op;
      data_mem_pkt_o.size_op = miss_fifo_entry_i.size_op;
      data_mem_pkt_o.byte_sel = addr_byte_sel(miss_fifo_entry_i.addr);
      data_mem_pkt_o.word = addr_word_off(miss_fifo_entry_i.addr);
    end
  end

endmodule

`default_nettype wire

// File: src/replacement_picker.sv
// replacement_picker: victim way for the set under miss
// invalid way first, then LRU, then lowest unlocked way
// eviction flag and tag of the chosen way

`default_nettype none

module replacement_picker (
  input  mhu_msg_pkg::set_state_s set_state_i,
  output mhu_msg_pkg::victim_s    victim_o
);

  import cache_geom_pkg::*;
  import mhu_msg_pkg::*;

  logic [ways_c-1:0] free_mask;
  logic [ways_c-1:0] unlocked_mask;
  logic free_found;
  way_t free_way;
  way_t backup_way;
  way_t chosen_way;

  // lowest set bit of a way mask
  function automatic way_t lowest_way(input logic [ways_c-1:0] mask);
    way_t way;
    way = '0;
    for (int i = ways_c - 1; i >= 0; i--) begin
      if (mask[i]) begin
        way = way_t'(i);
      end
    end
    return way;
  endfunction

  assign free_mask = ~set_state_i.valid & ~set_state_i.lock;
  assign unlocked_mask = ~set_state_i.lock;

  assign free_found = |free_mask;
  assign free_way = lowest_way(free_mask);
  // at least one way is always unlocked
  assign backup_way = lowest_way(unlocked_mask);

  always_comb begin
    if (free_found) begin
      chosen_way = free_way;
    end else if (set_state_i.lock[set_state_i.lru_way]) begin
      chosen_way = backup_way;
    end else begin
      chosen_way = set_state_i.lru_way;
    end
  end

  // write back only a valid dirty block
  assign victim_o.way = chosen_way;
  assign victim_o.evict = set_state_i.valid[chosen_way] & set_state_i.dirty[chosen_way];
  assign victim_o.evict_tag = set_state_i.tag[chosen_way];

endmodule

`default_nettype wire

// File: src/mhu_msg_pkg.sv
// mhu_msg_pkg: packets between the miss handling unit and its neighbours
// miss FIFO entry, set state, victim, DMA command
// tag, stat and data memory packets

`default_nettype none

package mhu_msg_pkg;

  import cache_geom_pkg::*;

  `include "mhu_settings.svh"

  typedef logic [`MHU_ID_WIDTH-1:0] id_t;

  // size_op encoding for a full data word
  localparam logic [1:0] size_word_c = 2'(byte_sel_width_c);

  typedef struct packed {
    id_t id;
    addr_t addr;
    logic write_not_read;
    logic block_load;
    logic [1:0] size_op;
    logic sigext_op;
    word_t data;
  } miss_entry_s;

  // tag and status memory contents of one set
  typedef struct packed {
    logic [ways_c-1:0] valid;
    logic [ways_c-1:0] lock;
    tag_t [ways_c-1:0] tag;
    logic [ways_c-1:0] dirty;
    way_t lru_way;
  } set_state_s;

  typedef struct packed {
    way_t way;
    logic evict;
    tag_t evict_tag;
  } victim_s;

  typedef struct packed {
    way_t way;
    index_t index;
    logic refill;
    tag_t refill_tag;
    logic evict;
    tag_t evict_tag;
  } dma_cmd_s;

  typedef enum logic {
    e_tag_read,
    e_tag_set_tag
  } tag_mem_op_e;

  typedef struct packed {
    tag_mem_op_e opcode;
    way_t way;
    index_t index;
    tag_t tag;
  } tag_mem_pkt_s;

  typedef enum logic {
    e_stat_read,
    e_stat_clear_dirty
  } stat_mem_op_e;

  typedef struct packed {
    stat_mem_op_e opcode;
    way_t way;
    index_t index;
  } stat_mem_pkt_s;

  typedef struct packed {
    logic write_not_read;
    logic sigext_op;
    logic [1:0] size_op;
    byte_sel_t byte_sel;
    way_t way;
    index_t index;
    word_off_t word;
    word_t data;
  } data_mem_pkt_s;

endpackage

`default_nettype wire

// File: src/cache_geom_pkg.sv
// cache_geom_pkg: address field widths of the data cache
// tag, index, way, word-offset and word types
// address field extraction helpers

`default_nettype none

package cache_geom_pkg;

  `include "mhu_settings.svh"

  localparam int addr_width_c = `MHU_ADDR_WIDTH;
  localparam int data_width_c = `MHU_DATA_WIDTH;
  localparam int ways_c = `MHU_WAYS;
  localparam int block_words_c = `MHU_BLOCK_WORDS;

  localparam int byte_sel_width_c = $clog2(data_width_c / 8);
  localparam int word_off_width_c = $clog2(block_words_c);
  localparam int index_width_c = $clog2(`MHU_SETS);
  localparam int way_width_c = $clog2(ways_c);
  localparam int block_off_width_c = word_off_width_c + byte_sel_width_c;
  localparam int tag_width_c = addr_width_c - index_width_c - block_off_width_c;

  typedef logic [addr_width_c-1:0] addr_t;
  typedef logic [tag_width_c-1:0] tag_t;
  typedef logic [index_width_c-1:0] index_t;
  typedef logic [way_width_c-1:0] way_t;
  typedef logic [word_off_width_c-1:0] word_off_t;
  typedef logic [byte_sel_width_c-1:0] byte_sel_t;
  typedef logic [data_width_c-1:0] word_t;

  // address layout is {tag, index, word offset, byte select}
  function automatic tag_t addr_tag(input addr_t addr);
    return addr[addr_width_c-1 -: tag_width_c];
  endfunction

  function automatic index_t addr_index(input addr_t addr);
    return addr[block_off_width_c +: index_width_c];
  endfunction

  function automatic word_off_t addr_word_off(input addr_t addr);
    return addr[byte_sel_width_c +: word_off_width_c];
  endfunction

  function automatic byte_sel_t addr_byte_sel(input addr_t addr);
    return addr[0 +: byte_sel_width_c];
  endfunction

endpackage

`default_nettype wire

// File: src/mhu_settings.svh
// cache geometry for the miss handling unit
// address, word, way, set, block size and request id width

`ifndef MHU_SETTINGS_SVH
`define MHU_SETTINGS_SVH

// byte address width
`define MHU_ADDR_WIDTH 32

// data word width
`define MHU_DATA_WIDTH 32

// set-associative geometry
`define MHU_WAYS 4
`define MHU_SETS 64
`define MHU_BLOCK_WORDS 8

// id carried through the miss FIFO
`define MHU_ID_WIDTH 4

`endif
